// File: Bender.yml
package:
  name: digital_clock

sources:
  - files:
      - verilog/clock_time_pkg.sv
      - verilog/clock_ui_pkg.sv
      - verilog/tick_gen.sv
      - verilog/key_debounce.sv
      - verilog/mode_ctrl.sv
      - verilog/hms_counter.sv
      - verilog/alarm_unit.sv
      - verilog/seg_display.sv
      - verilog/digital_clock.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/clock_checker.sv
      - verif/tb_digital_clock.sv

// File: digital_clock.f
verilog/clock_time_pkg.sv
verilog/clock_ui_pkg.sv
verilog/tick_gen.sv
verilog/key_debounce.sv
verilog/mode_ctrl.sv
verilog/hms_counter.sv
verilog/alarm_unit.sv
verilog/seg_display.sv
verilog/digital_clock.sv
verif/tb_clk_gen.sv
verif/clock_checker.sv
verif/tb_digital_clock.sv

// File: verif/clock_checker.sv
// watches the display and alarm pins, decodes the scan back into digits
// all sampling on the falling clk edge, FRAME is one full scan in cycles
// a digit counts as blank when it is never lit during a frame

`timescale 1ns/1ps

module clock_checker #(
	parameter int FRAME = 48
) (
	input logic                    clk,
	input clock_ui_pkg::seg_t      i_seg,
	input logic                    i_seg_dp,
	input clock_ui_pkg::digit_en_t i_seg_enb,
	input logic                    i_alarm,
	input logic                    i_buzz
);
	import clock_time_pkg::*;
	import clock_ui_pkg::*;

	int n_tests   = 0;
	int n_errors  = 0;
	int test_errs = 0;

	function automatic logic [3:0] seg_to_digit(seg_t s);
		case (s)
			7'b111_1110: return 4'd0;
			7'b011_0000: return 4'd1;
			7'b110_1101: return 4'd2;
			7'b111_1001: return 4'd3;
			7'b011_0011: return 4'd4;
			7'b101_1011: return 4'd5;
			7'b101_1111: return 4'd6;
			7'b111_0000: return 4'd7;
			7'b111_1111: return 4'd8;
			7'b111_0011: return 4'd9;
			default:     return 4'hf;	// not a digit
		endcase
	endfunction

	function automatic string fmt_time(hms_time_t t);
		return $sformatf("%02d:%02d:%02d", t.hour, t.min, t.sec);
	endfunction

	// ------------------------------
	// bookkeeping
	// ------------------------------
	task automatic start_test();
		test_errs = 0;
	endtask

	task automatic end_test(string name);
		n_tests++;
		n_errors += test_errs;
		$display("%s: %s", name, (test_errs == 0) ? "ok" : "FAILED");
	endtask

	task automatic value_error(string name, string what, string exp, string act);
		$display("** Error %s: %s expected %s, actual %s", name, what, exp, act);
		test_errs++;
	endtask

	task automatic plain_error(string name, string msg);
		$display("%s: %s", name, msg);
		test_errs++;
	endtask

	// ------------------------------
	// frame capture
	// ------------------------------
	task automatic read_frame(output hms_time_t t, output logic [5:0] lit,
			output logic [5:0] dp);
		logic [3:0] dig [NUM_DIGITS];
		digit_en_t  sel;
		lit = '0;
		dp  = '0;
		foreach (dig[i])
			dig[i] = 4'd0;
		repeat (FRAME) begin
			@(negedge clk);
			for (int k = 0; k < NUM_DIGITS; k++) begin
				sel = ~(digit_en_t'(1) << k);
				if (i_seg_enb == sel) begin
					lit[k] = 1'b1;
					dig[k] = seg_to_digit(i_seg);
					if (i_seg_dp)
						dp[k] = 1'b1;
				end
			end
		end
		t.sec  = 6'(dig[1] * 10 + dig[0]);
		t.min  = 6'(dig[3] * 10 + dig[2]);
		t.hour = 6'(dig[5] * 10 + dig[4]);
	endtask

	// skips frames caught in the blink-off phase
	task automatic read_lit_frame(output hms_time_t t, output logic [5:0] dp, output bit ok);
		logic [5:0] lit;
		ok = 1'b0;
		for (int n = 0; n < 40 && !ok; n++) begin
			read_frame(t, lit, dp);
			ok = (lit == 6'h3f);
		end
	endtask

	// ------------------------------
	// checks
	// ------------------------------
	task automatic check_display(string name, hms_time_t exp, logic [5:0] exp_dp);
		hms_time_t  t;
		logic [5:0] dp;
		bit         ok;
		read_lit_frame(t, dp, ok);
		if (!ok)
			plain_error(name, "display never showed all six digits lit");
		else begin
			if (t != exp)
				value_error(name, "time", fmt_time(exp), fmt_time(t));
			if (dp != exp_dp)
				value_error(name, "dp mask", $sformatf("%b", exp_dp), $sformatf("%b", dp));
		end
	endtask

	// a second may roll over inside a frame, so a few frames are tried
	task automatic check_running(string name, hms_time_t lo, hms_time_t hi);
		hms_time_t  t;
		logic [5:0] lit, dp;
		bit         match;
		match = 1'b0;
		for (int n = 0; n < 3 && !match; n++) begin
			read_frame(t, lit, dp);
			match = (lit == 6'h3f) && (t == lo || t == hi);
		end
		if (!match)
			value_error(name, "time", {fmt_time(lo), " or ", fmt_time(hi)}, fmt_time(t));
	endtask

	task automatic check_blink(string name, logic [5:0] mask, int cycles);
		hms_time_t  t;
		logic [5:0] lit, dp;
		bit         saw_blank, saw_lit;
		saw_blank = 1'b0;
		saw_lit   = 1'b0;
		for (int n = 0; n < cycles / FRAME; n++) begin
			read_frame(t, lit, dp);
			if ((lit & mask) == '0)
				saw_blank = 1'b1;
			if ((lit & mask) == mask)
				saw_lit = 1'b1;
		end
		if (!saw_blank)
			plain_error(name, "selected field was never blanked");
		if (!saw_lit)
			plain_error(name, "selected field was never lit");
	endtask

	task automatic check_steady(string name, int frames);
		hms_time_t  t;
		logic [5:0] lit, dp;
		bit         blank_seen, dp_seen;
		blank_seen = 1'b0;
		dp_seen    = 1'b0;
		repeat (frames) begin
			read_frame(t, lit, dp);
			blank_seen |= (lit != 6'h3f);
			dp_seen    |= (dp != '0);
		end
		if (blank_seen)
			plain_error(name, "a digit went blank in clock mode");
		if (dp_seen)
			plain_error(name, "a decimal point was lit in clock mode");
	endtask

	task automatic wait_alarm(string name, int timeout);
		int n;
		n = 0;
		while (!i_alarm && n < timeout) begin
			@(negedge clk);
			n++;
		end
		if (!i_alarm)
			plain_error(name, "o_alarm did not rise before the timeout");
	endtask

	task automatic check_buzz(string name, int cycles, bit active);
		int   toggles;
		logic prev;
		bit   alarm_bad, buzz_bad;
		toggles   = 0;
		alarm_bad = 1'b0;
		buzz_bad  = 1'b0;
		prev      = i_buzz;
		repeat (cycles) begin
			@(negedge clk);
			if (i_alarm !== active)
				alarm_bad = 1'b1;
			if (!active && i_buzz !== 1'b0)
				buzz_bad = 1'b1;
			if (i_buzz !== prev)
				toggles++;
			prev = i_buzz;
		end
		if (alarm_bad)
			value_error(name, "o_alarm", active ? "1" : "0", active ? "0" : "1");
		if (active && toggles == 0)
			plain_error(name, "o_buzz never toggled while the alarm was on");
		if (buzz_bad)
			plain_error(name, "o_buzz was not silent");
	endtask

endmodule

// File: verif/tb_clk_gen.sv
// 8 ns clock, rst_n low for the first 8 rising edges
// release comes 1 ns after an edge, like the other stimulus

`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule

// File: verif/tb_digital_clock.sv
// testbench for the alarm clock with shortened dividers
// one second is SEC_DIV cycles, a key press is 40 cycles high and 40 low
// expected times come from a small hh:mm:ss model below

`timescale 1ns/1ps

module tb_digital_clock;
	import clock_time_pkg::*;
	import clock_ui_pkg::*;

	localparam int SEC_DIV   = 4000;
	localparam int SCAN_DIV  = 8;
	localparam int BLINK_DIV = 200;
	localparam int FRAME     = NUM_DIGITS * SCAN_DIV;

	localparam key_bus_t KEY_MODE  = 4'b1000;
	localparam key_bus_t KEY_POS   = 4'b0100;
	localparam key_bus_t KEY_ADJ   = 4'b0010;
	localparam key_bus_t KEY_ALARM = 4'b0001;

	logic      clk, rst_n;
	key_bus_t  keys;
	seg_t      seg;
	logic      seg_dp, alarm, buzz;
	digit_en_t seg_enb;

	tb_clk_gen clk_gen_inst (.clk(clk), .rst_n(rst_n));

	digital_clock #(
		.SEC_DIV   (SEC_DIV),
		.SCAN_DIV  (SCAN_DIV),
		.BLINK_DIV (BLINK_DIV),
		.DEB_DIV   (4),
		.TONE_DIV  (3)
	) digital_clock_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_keys    (keys),
		.o_seg     (seg),
		.o_seg_dp  (seg_dp),
		.o_seg_enb (seg_enb),
		.o_alarm   (alarm),
		.o_buzz    (buzz)
	);

	clock_checker #(.FRAME(FRAME)) clock_checker_inst (
		.clk       (clk),
		.i_seg     (seg),
		.i_seg_dp  (seg_dp),
		.i_seg_enb (seg_enb),
		.i_alarm   (alarm),
		.i_buzz    (buzz)
	);

	// ------------------------------
	// model
	// ------------------------------
	function automatic hms_time_t advance(hms_time_t t, int n);
		hms_time_t r;
		r = t;
		repeat (n) begin
			if (r.sec == SEC_MAX) begin
				r.sec = 0;
				if (r.min == MIN_MAX) begin
					r.min  = 0;
					r.hour = (r.hour == HOUR_MAX) ? 6'd0 : r.hour + 6'd1;
				end else
					r.min = r.min + 6'd1;
			end else
				r.sec = r.sec + 6'd1;
		end
		return r;
	endfunction

	// ------------------------------
	// stimulus
	// ------------------------------
	task automatic press_key(key_bus_t k);
		@(posedge clk);
		#1 keys = k;
		repeat (40) @(posedge clk);
		#1 keys = '0;
		repeat (39) @(posedge clk);
	endtask

	task automatic press_n(key_bus_t k, int n);
		repeat (n) press_key(k);
	endtask

	task automatic wait_cycles(int n);
		for (int i = 0; i < n; i++)
			@(posedge clk);
	endtask

	// steps one field from cur to tgt, then moves to the next field
	task automatic step_field(int cur, int tgt, int lim);
		press_n(KEY_ADJ, (tgt - cur + lim + 1) % (lim + 1));
		press_key(KEY_POS);
	endtask

	initial begin
		hms_time_t model, alarm_t;
		int        n_sec, n_min, n_hour, k, tgt_sec, wait_n;
		keys = '0;
		void'($urandom(32'hed0));
		clock_checker_inst.start_test();
		wait_n = 0;
		while (!rst_n && wait_n < 100) begin
			@(posedge clk);
			wait_n++;
		end
		if (!rst_n)
			clock_checker_inst.plain_error("reset_state", "rst_n was never released");
		wait_cycles(100);

		clock_checker_inst.check_display("reset_state", '0, 6'b000000);
		clock_checker_inst.check_buzz("reset_state", 50, 1'b0);
		clock_checker_inst.end_test("reset_state");

		// setup mode, random presses on each field
		clock_checker_inst.start_test();
		press_key(KEY_MODE);
		n_sec  = $urandom_range(70, 0);
		n_min  = $urandom_range(70, 0);
		n_hour = $urandom_range(70, 0);
		press_n(KEY_ADJ, n_sec);
		press_key(KEY_POS);
		press_n(KEY_ADJ, n_min);
		press_key(KEY_POS);
		press_n(KEY_ADJ, n_hour);
		press_key(KEY_POS);
		model.sec  = 6'(n_sec % (SEC_MAX + 1));
		model.min  = 6'(n_min % (MIN_MAX + 1));
		model.hour = 6'(n_hour % (HOUR_MAX + 1));
		clock_checker_inst.check_display("setup_steps", model, 6'b000001);
		wait_cycles(3 * SEC_DIV);
		clock_checker_inst.check_display("setup_steps", model, 6'b000001);
		clock_checker_inst.end_test("setup_steps");

		clock_checker_inst.start_test();
		clock_checker_inst.check_blink("setup_blink", 6'b000011, 2 * BLINK_DIV * 2);
		clock_checker_inst.end_test("setup_blink");

		// near midnight so the run wraps to 00:00
		clock_checker_inst.start_test();
		tgt_sec = 50 + $urandom_range(9, 0);
		step_field(model.sec, tgt_sec, 59);
		step_field(model.min, 59, 59);
		step_field(model.hour, 23, 23);
		model = '{hour: 6'd23, min: 6'd59, sec: 6'(tgt_sec)};
		clock_checker_inst.check_display("clock_run", model, 6'b000001);
		press_n(KEY_MODE, 2);	// through alarm back to clock
		k = 10 + $urandom_range(5, 0);
		wait_cycles(k * SEC_DIV);
		clock_checker_inst.check_running("clock_run", advance(model, k), advance(model, k + 1));
		clock_checker_inst.end_test("clock_run");

		clock_checker_inst.start_test();
		clock_checker_inst.check_steady("clock_steady", 20);
		clock_checker_inst.end_test("clock_steady");

		// alarm about five seconds ahead of the running time
		clock_checker_inst.start_test();
		alarm_t = advance(model, k + 6);
		press_n(KEY_MODE, 2);
		step_field(0, alarm_t.sec, 59);
		step_field(0, alarm_t.min, 59);
		step_field(0, alarm_t.hour, 23);
		clock_checker_inst.check_display("alarm", alarm_t, 6'b000001);
		press_key(KEY_ALARM);
		press_key(KEY_MODE);
		clock_checker_inst.wait_alarm("alarm", 7 * SEC_DIV);
		clock_checker_inst.check_running("alarm", alarm_t, advance(alarm_t, 1));
		clock_checker_inst.check_buzz("alarm", 2 * SEC_DIV, 1'b1);
		press_key(KEY_ALARM);
		clock_checker_inst.check_buzz("alarm", 200, 1'b0);
		clock_checker_inst.end_test("alarm");

		$display("tests run: %0d, errors: %0d", clock_checker_inst.n_tests,
			clock_checker_inst.n_errors);
		if (clock_checker_inst.n_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: verilog/alarm_unit.sv
// alarm latch and single tone buzzer
// latch sets on an exact hh:mm:ss match and holds until enable drops
// o_buzz is a square wave at clk / (2 * TONE_DIV)

`timescale 1ns/1ps

module alarm_unit #(
	parameter clock_time_pkg::div_cnt_t TONE_DIV = clock_time_pkg::DEF_TONE_DIV
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  clock_time_pkg::hms_time_t i_cur_time,
	input  clock_time_pkg::hms_time_t i_alarm_time,
	input  logic                      i_alarm_en,
	output logic                      o_alarm,
	output logic                      o_buzz
);
	import clock_time_pkg::*;

	logic tone_tick;
	logic buzz_q;

	tick_gen #(.DIV(TONE_DIV)) tone_gen_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (tone_tick)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
			buzz_q  <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en && (o_alarm || i_cur_time == i_alarm_time);
			if (!o_alarm)
				buzz_q <= 1'b0;
			else if (tone_tick)
				buzz_q <= ~buzz_q;
		end
	end

	assign o_buzz = buzz_q & o_alarm;	// silent the moment the latch clears

endmodule

// File: verilog/clock_time_pkg.sv
// time base and field limits for the wall clock
// default dividers assume a 50 MHz clk
// fields are plain binary, split into BCD digits only at the display

package clock_time_pkg;

	// ------------------------------
	// divider counts
	// ------------------------------
	localparam int unsigned DIV_W = 32;

	typedef logic [DIV_W-1:0] div_cnt_t;

	localparam div_cnt_t DEF_SEC_DIV   = 32'd50_000_000;	// 1 Hz
	localparam div_cnt_t DEF_SCAN_DIV  = 32'd5_000;	// 10 kHz digit scan
	localparam div_cnt_t DEF_BLINK_DIV = 32'd12_500_000;	// 4 Hz blink phase toggle
	localparam div_cnt_t DEF_DEB_DIV   = 32'd500_000;	// 100 Hz key sampling
	localparam div_cnt_t DEF_TONE_DIV  = 32'd28_409;	// buzzer half period, ~880 Hz

	// ------------------------------
	// time fields
	// ------------------------------
	typedef logic [5:0] time_field_t;

	localparam time_field_t SEC_MAX  = 6'd59;
	localparam time_field_t MIN_MAX  = 6'd59;
	localparam time_field_t HOUR_MAX = 6'd23;	// 24 h format only

	typedef struct packed {
		time_field_t hour;
		time_field_t min;
		time_field_t sec;
	} hms_time_t;

endpackage

// File: verilog/clock_ui_pkg.sv
// user side types: modes, field select, keys and the LED display
// segments and keys are active high, digit enables active low

package clock_ui_pkg;

	// ------------------------------
	// modes and field select
	// ------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC  = 2'd0,
		POS_MIN  = 2'd1,
		POS_HOUR = 2'd2
	} pos_t;

	typedef struct packed {
		logic mode;	// cycle clock / setup / alarm
		logic pos;	// cycle selected field
		logic adj;	// step selected field
		logic alarm;	// toggle alarm enable
	} key_bus_t;

	typedef struct packed {
		logic sec;
		logic min;
		logic hour;
	} step_t;

	// ------------------------------
	// display
	// ------------------------------
	localparam int unsigned NUM_DIGITS = 6;

	typedef logic [6:0]            seg_t;	// {a,b,c,d,e,f,g}
	typedef logic [NUM_DIGITS-1:0] digit_en_t;	// bit 0 is seconds units

endpackage

// File: verilog/digital_clock.sv
// top of the alarm clock, single clk domain, all rates are enable strobes
// divider parameters default to 50 MHz values and may be shortened
// i_keys are raw asynchronous levels, active high

`timescale 1ns/1ps

module digital_clock #(
	parameter clock_time_pkg::div_cnt_t SEC_DIV   = clock_time_pkg::DEF_SEC_DIV,
	parameter clock_time_pkg::div_cnt_t SCAN_DIV  = clock_time_pkg::DEF_SCAN_DIV,
	parameter clock_time_pkg::div_cnt_t BLINK_DIV = clock_time_pkg::DEF_BLINK_DIV,
	parameter clock_time_pkg::div_cnt_t DEB_DIV   = clock_time_pkg::DEF_DEB_DIV,
	parameter clock_time_pkg::div_cnt_t TONE_DIV  = clock_time_pkg::DEF_TONE_DIV
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  clock_ui_pkg::key_bus_t  i_keys,
	output clock_ui_pkg::seg_t      o_seg,
	output logic                    o_seg_dp,
	output clock_ui_pkg::digit_en_t o_seg_enb,
	output logic                    o_alarm,
	output logic                    o_buzz
);
	import clock_time_pkg::*;
	import clock_ui_pkg::*;

	logic      sec_tick, scan_tick, blink_tick, deb_tick;
	key_bus_t  presses;
	mode_t     mode;
	pos_t      pos;
	logic      alarm_en, time_run;
	step_t     time_step, alarm_step;
	hms_time_t cur_time, alarm_time, show_time;

	// ------------------------------
	// rate strobes
	// ------------------------------
	tick_gen #(.DIV(SEC_DIV))   sec_tick_inst   (.clk(clk), .rst_n(rst_n), .o_tick(sec_tick));
	tick_gen #(.DIV(SCAN_DIV))  scan_tick_inst  (.clk(clk), .rst_n(rst_n), .o_tick(scan_tick));
	tick_gen #(.DIV(BLINK_DIV)) blink_tick_inst (.clk(clk), .rst_n(rst_n), .o_tick(blink_tick));
	tick_gen #(.DIV(DEB_DIV))   deb_tick_inst   (.clk(clk), .rst_n(rst_n), .o_tick(deb_tick));

	key_debounce key_debounce_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_keys   (i_keys),
		.i_sample (deb_tick),
		.o_press  (presses)
	);

	mode_ctrl mode_ctrl_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_press      (presses),
		.i_sec_tick   (sec_tick),
		.i_cur_time   (cur_time),
		.i_alarm_time (alarm_time),
		.o_mode       (mode),
		.o_pos        (pos),
		.o_alarm_en   (alarm_en),
		.o_time_run   (time_run),
		.o_time_step  (time_step),
		.o_alarm_step (alarm_step),
		.o_show_time  (show_time)
	);

	// ------------------------------
	// time and alarm registers
	// ------------------------------
	hms_counter time_cnt_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_run  (time_run),
		.i_step (time_step),
		.o_time (cur_time)
	);

	hms_counter alarm_cnt_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_run  (1'b0),	// alarm setting never runs
		.i_step (alarm_step),
		.o_time (alarm_time)
	);

	alarm_unit #(.TONE_DIV(TONE_DIV)) alarm_unit_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_cur_time   (cur_time),
		.i_alarm_time (alarm_time),
		.i_alarm_en   (alarm_en),
		.o_alarm      (o_alarm),
		.o_buzz       (o_buzz)
	);

	seg_display seg_display_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_scan_tick  (scan_tick),
		.i_blink_tick (blink_tick),
		.i_show_time  (show_time),
		.i_mode       (mode),
		.i_pos        (pos),
		.o_seg        (o_seg),
		.o_seg_dp     (o_seg_dp),
		.o_seg_enb    (o_seg_enb)
	);

endmodule

// File: verilog/hms_counter.sv
// hh:mm:ss counter, used for both the time and the alarm setting
// i_run advances seconds with carry into min and hour
// a step bit bumps only its own field, wraps, and carries nothing

`timescale 1ns/1ps

module hms_counter (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      i_run,
	input  clock_ui_pkg::step_t       i_step,
	output clock_time_pkg::hms_time_t o_time
);
	import clock_time_pkg::*;
	import clock_ui_pkg::*;

	hms_time_t time_q;

	function automatic time_field_t wrap_inc(time_field_t v, time_field_t lim);
		return (v == lim) ? '0 : v + 1'b1;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_q <= '0;
		end else if (i_run) begin
			time_q.sec <= wrap_inc(time_q.sec, SEC_MAX);
			if (time_q.sec == SEC_MAX) begin	// carry into minutes
				time_q.min <= wrap_inc(time_q.min, MIN_MAX);
				if (time_q.min == MIN_MAX)
					time_q.hour <= wrap_inc(time_q.hour, HOUR_MAX);
			end
		end else begin
			// manual stepping
			if (i_step.sec)
				time_q.sec <= wrap_inc(time_q.sec, SEC_MAX);
			if (i_step.min)
				time_q.min <= wrap_inc(time_q.min, MIN_MAX);
			if (i_step.hour)
				time_q.hour <= wrap_inc(time_q.hour, HOUR_MAX);
		end
	end

	assign o_time = time_q;

	a_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_time.sec <= SEC_MAX && o_time.min <= MIN_MAX && o_time.hour <= HOUR_MAX);

endmodule

// File: verilog/key_debounce.sv
// debounce for the four keys, sampled on i_sample strobes
// a key must read high on two samples in a row to count
// o_press gives one pulse per press, never a repeat while held

`timescale 1ns/1ps

module key_debounce (
	input  logic                   clk,
	input  logic                   rst_n,
	input  clock_ui_pkg::key_bus_t i_keys,
	input  logic                   i_sample,
	output clock_ui_pkg::key_bus_t o_press
);
	import clock_ui_pkg::*;

	key_bus_t sync1_q, sync2_q;	// metastability guard
	key_bus_t samp0_q, samp1_q;	// latest and previous sample
	key_bus_t level_q;	// filtered key level

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1_q <= '0;
			sync2_q <= '0;
			samp0_q <= '0;
			samp1_q <= '0;
			level_q <= '0;
			o_press <= '0;
		end else begin
			sync1_q <= i_keys;
			sync2_q <= sync1_q;
			if (i_sample) begin
				samp0_q <= sync2_q;
				samp1_q <= samp0_q;
			end
			// set on two highs, clear on two lows, else hold
			level_q <= (samp0_q & samp1_q) | (level_q & (samp0_q | samp1_q));
			o_press <= samp0_q & samp1_q & ~level_q;	// rising edge of level
		end
	end

	a_press_single: assert property (@(posedge clk) disable iff (!rst_n)
		(o_press & $past(o_press)) == '0);

endmodule

// File: verilog/mode_ctrl.sv
// mode FSM, field select and alarm enable, all moved by key pulses
// adj pulses are routed to the time or alarm counter by mode
// time is frozen in setup mode, keeps running in alarm mode

`timescale 1ns/1ps

module mode_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	input  clock_ui_pkg::key_bus_t  i_press,
	input  logic                    i_sec_tick,
	input  clock_time_pkg::hms_time_t i_cur_time,
	input  clock_time_pkg::hms_time_t i_alarm_time,
	output clock_ui_pkg::mode_t     o_mode,
	output clock_ui_pkg::pos_t      o_pos,
	output logic                    o_alarm_en,
	output logic                    o_time_run,
	output clock_ui_pkg::step_t     o_time_step,
	output clock_ui_pkg::step_t     o_alarm_step,
	output clock_time_pkg::hms_time_t o_show_time
);
	import clock_time_pkg::*;
	import clock_ui_pkg::*;

	mode_t mode_q;
	pos_t  pos_q;
	step_t sel_step;	// one bit for the selected field

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q     <= MODE_CLOCK;
			pos_q      <= POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (i_press.mode) begin
				case (mode_q)
					MODE_CLOCK: mode_q <= MODE_SETUP;
					MODE_SETUP: mode_q <= MODE_ALARM;
					default:    mode_q <= MODE_CLOCK;
				endcase
			end
			if (i_press.pos) begin
				case (pos_q)
					POS_SEC: pos_q <= POS_MIN;
					POS_MIN: pos_q <= POS_HOUR;
					default: pos_q <= POS_SEC;
				endcase
			end
			if (i_press.alarm)
				o_alarm_en <= ~o_alarm_en;
		end
	end

	// ------------------------------
	// step routing
	// ------------------------------
	always_comb begin
		sel_step      = '0;
		sel_step.sec  = (pos_q == POS_SEC);
		sel_step.min  = (pos_q == POS_MIN);
		sel_step.hour = (pos_q == POS_HOUR);
	end

	assign o_time_step  = (i_press.adj && mode_q == MODE_SETUP) ? sel_step : '0;
	assign o_alarm_step = (i_press.adj && mode_q == MODE_ALARM) ? sel_step : '0;
	assign o_time_run   = i_sec_tick && (mode_q != MODE_SETUP);
	assign o_show_time  = (mode_q == MODE_ALARM) ? i_alarm_time : i_cur_time;
	assign o_mode       = mode_q;
	assign o_pos        = pos_q;

	a_one_step: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({o_time_step, o_alarm_step}));

endmodule

// File: verilog/seg_display.sv
// six digit multiplexed LED driver, one digit lit per scan slot
// digit 0 is seconds units, digit 5 hour tens
// in setup and alarm modes the selected field blinks and carries the dp
// a blanked digit has all enables high for its slot

`timescale 1ns/1ps

module seg_display (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      i_scan_tick,
	input  logic                      i_blink_tick,
	input  clock_time_pkg::hms_time_t i_show_time,
	input  clock_ui_pkg::mode_t       i_mode,
	input  clock_ui_pkg::pos_t        i_pos,
	output clock_ui_pkg::seg_t        o_seg,
	output logic                      o_seg_dp,
	output clock_ui_pkg::digit_en_t   o_seg_enb
);
	import clock_time_pkg::*;
	import clock_ui_pkg::*;

	localparam int unsigned IDX_W = $clog2(NUM_DIGITS);

	typedef logic [IDX_W-1:0] idx_t;

	idx_t        idx_q, idx_nxt;
	logic        blink_on_q;	// high in the lit half of the blink
	time_field_t field;
	logic [3:0]  digit_val;
	logic        digit_sel, blank;

	function automatic seg_t seg_decode(logic [3:0] d);
		case (d)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;
		endcase
	endfunction

	// ------------------------------
	// next digit and its contents
	// ------------------------------
	always_comb begin
		idx_nxt = idx_q;
		if (i_scan_tick)
			idx_nxt = (idx_q == idx_t'(NUM_DIGITS - 1)) ? '0 : idx_q + 1'b1;
		case (idx_nxt[IDX_W-1:1])	// two digits per field
			2'd0:    field = i_show_time.sec;
			2'd1:    field = i_show_time.min;
			default: field = i_show_time.hour;
		endcase
		digit_val = idx_nxt[0] ? 4'(field / 6'd10) : 4'(field % 6'd10);
		digit_sel = (i_mode != MODE_CLOCK) && (idx_nxt[IDX_W-1:1] == i_pos);
		blank     = digit_sel && !blink_on_q;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx_q      <= '0;
			blink_on_q <= 1'b1;
			o_seg      <= '0;
			o_seg_dp   <= 1'b0;
			o_seg_enb  <= ~digit_en_t'(1);	// digit 0
		end else begin
			idx_q <= idx_nxt;
			if (i_blink_tick)
				blink_on_q <= ~blink_on_q;
			o_seg     <= blank ? '0 : seg_decode(digit_val);
			o_seg_dp  <= digit_sel && !blank && !idx_nxt[0];	// units digit only
			o_seg_enb <= blank ? '1 : ~(digit_en_t'(1) << idx_nxt);
		end
	end

endmodule

// File: verilog/tick_gen.sv
// one-cycle enable strobe every DIV clk cycles
// first strobe lands DIV cycles after reset release

`timescale 1ns/1ps

module tick_gen #(
	parameter clock_time_pkg::div_cnt_t DIV = 2
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);
	import clock_time_pkg::*;

	div_cnt_t cnt_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q  <= '0;
			o_tick <= 1'b0;
		end else begin
			o_tick <= (cnt_q == DIV - 1'b1);
			cnt_q  <= (cnt_q == DIV - 1'b1) ? '0 : cnt_q + 1'b1;	// wrap at DIV-1
		end
	end

	a_div_min: assert property (@(posedge clk) disable iff (!rst_n) DIV >= 2);

endmodule
